//--- source/serial_pkg.sv
package serial_pkg;

   // one instruction, address or data word
   typedef logic [31:0] word_t;

   // widths of the bit counter and of a register index
   localparam int CNT_W      = 5;
   localparam int REG_ADDR_W = 5;

   // INIT is the first pass of branches, SLT and SW, WAIT holds a data-bus cycle
   typedef enum logic [1:0] {IDLE, INIT, RUN, WAIT} state_t;

   // opcode field, instruction bits 6:2
   typedef enum logic [4:0] {
      OPC_OPIMM  = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JAL    = 5'b11011
   } opcode_t;

   // alu result select
   typedef enum logic [1:0] {ALU_ADD, ALU_LT, ALU_BOOL} alu_sel_t;

   // boolean op, straight from funct3[1:0]
   typedef enum logic [1:0] {BOOL_XOR = 2'b00, BOOL_OR = 2'b10, BOOL_AND = 2'b11} bool_op_t;

   // where rd gets its bit from
   typedef enum logic [1:0] {RD_ALU, RD_PC, RD_IMM} rd_src_t;

endpackage

//--- source/alu_ctrl_if.sv
`timescale 1ns/1ps
interface alu_ctrl_if;
   import serial_pkg::*;

   logic     en;
   logic     init;
   logic     sub;
   bool_op_t bool_op;
   logic     cmp_eq;
   logic     cmp_uns;
   alu_sel_t rd_sel;
   logic     op_b_imm;
   // compare result going back to the decoder
   logic     cmp;

   modport decode (
      output en, init, sub, bool_op, cmp_eq, cmp_uns, rd_sel, op_b_imm,
      input  cmp
   );

   modport alu (
      input  en, init, sub, bool_op, cmp_eq, cmp_uns, rd_sel, op_b_imm,
      output cmp
   );

endinterface

//--- source/serial_decode.sv
`timescale 1ns/1ps
module serial_decode (
   input  logic                                clk,
   input  logic                                i_rst,
   input  logic                                i_ibus_ack,
   input  serial_pkg::word_t                   i_ibus_rdt,
   input  logic                                i_rf_ready,
   input  logic                                i_dbus_ack,
   output logic [serial_pkg::CNT_W-1:0]        o_cnt,
   output logic                                o_cnt_done,
   output logic                                o_rf_rs_en,
   output logic                                o_rf_rd_en,
   output logic [serial_pkg::REG_ADDR_W-1:0]   o_rf_rd_addr,
   output logic [serial_pkg::REG_ADDR_W-1:0]   o_rf_rs1_addr,
   output logic [serial_pkg::REG_ADDR_W-1:0]   o_rf_rs2_addr,
   output logic                                o_imm,
   output serial_pkg::rd_src_t                 o_rd_sel_src,
   output logic                                o_pc_en,
   output logic                                o_jump,
   output logic                                o_bufreg_en,
   output logic                                o_dbus_cyc,
   alu_ctrl_if.decode                          alu
);
   import serial_pkg::*;

   state_t     state;
   opcode_t    opcode;
   logic [2:0] funct3;
   logic       op30;
   word_t      imm;
   logic       fetched;
   logic       taken_r;
   logic       cnt_en;
   logic       op_or_opimm;
   logic       slt_op;
   logic       branch_op;
   logic       store_op;
   logic       two_stage;
   logic       take_branch;

   assign op_or_opimm = (opcode == OPC_OP) || (opcode == OPC_OPIMM);
   assign slt_op      = op_or_opimm && (funct3[2:1] == 2'b01);
   assign branch_op   = (opcode == OPC_BRANCH);
   assign store_op    = (opcode == OPC_STORE);
   // these need a first pass before the pc or rd can be touched
   assign two_stage   = slt_op || branch_op || store_op;

   assign cnt_en     = (state == INIT) || (state == RUN);
   assign o_cnt_done = cnt_en && (&o_cnt);
   assign o_imm      = imm[0];

   assign alu.en       = cnt_en;
   assign alu.init     = (state == INIT);
   assign alu.sub      = (opcode == OPC_OP) && op30;
   assign alu.bool_op  = bool_op_t'(funct3[1:0]);
   assign alu.cmp_eq   = (funct3[2:1] == 2'b00);
   // sltu, sltiu, bltu and bgeu
   assign alu.cmp_uns  = (funct3[1:0] == 2'b11) || (funct3[2:1] == 2'b11);
   assign alu.op_b_imm = (opcode == OPC_OPIMM);

   always_comb begin
      if (funct3 == 3'b000) begin
         alu.rd_sel = ALU_ADD;
      end else if (funct3[2:1] == 2'b01) begin
         alu.rd_sel = ALU_LT;
      end else begin
         alu.rd_sel = ALU_BOOL;
      end
   end

   // beq, blt, bltu take on a true compare; bne, bge, bgeu on a false one
   assign take_branch = branch_op && (alu.cmp ^ funct3[0]);

   assign o_jump      = (opcode == OPC_JAL) || taken_r;
   assign o_pc_en     = (state == RUN) || ((state == INIT) && store_op);
   assign o_rf_rs_en  = fetched || cnt_en;
   assign o_rf_rd_en  = (state == RUN) && (op_or_opimm || (opcode == OPC_LUI) ||
                        (opcode == OPC_AUIPC) || (opcode == OPC_JAL));
   assign o_bufreg_en = (state == INIT) && store_op;
   assign o_dbus_cyc  = (state == WAIT);

   always_comb begin
      case (opcode)
         OPC_LUI:   o_rd_sel_src = RD_IMM;
         OPC_AUIPC: o_rd_sel_src = RD_PC;
         OPC_JAL:   o_rd_sel_src = RD_PC;
         default:   o_rd_sel_src = RD_ALU;
      endcase
   end

   // instruction fields are latched and the immediate rotates LSB first while counting
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         opcode        <= opcode_t'(i_ibus_rdt[6:2]);
         funct3        <= i_ibus_rdt[14:12];
         op30          <= i_ibus_rdt[30];
         o_rf_rd_addr  <= i_ibus_rdt[11:7];
         o_rf_rs1_addr <= i_ibus_rdt[19:15];
         o_rf_rs2_addr <= i_ibus_rdt[24:20];
         case (i_ibus_rdt[6:2])
            OPC_LUI, OPC_AUIPC: begin
               imm <= {i_ibus_rdt[31:12], 12'b0};
            end
            OPC_JAL: begin
               imm <= {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                       i_ibus_rdt[30:21], 1'b0};
            end
            OPC_BRANCH: begin
               imm <= {{20{i_ibus_rdt[31]}}, i_ibus_rdt[7], i_ibus_rdt[30:25],
                       i_ibus_rdt[11:8], 1'b0};
            end
            OPC_STORE: begin
               imm <= {{21{i_ibus_rdt[31]}}, i_ibus_rdt[30:25], i_ibus_rdt[11:7]};
            end
            default: begin
               imm <= {{21{i_ibus_rdt[31]}}, i_ibus_rdt[30:20]};
            end
         endcase
      end else if (cnt_en) begin
         imm <= {imm[0], imm[31:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state   <= IDLE;
         o_cnt   <= '0;
         fetched <= 1'b0;
         taken_r <= 1'b0;
      end else begin
         if (cnt_en) begin
            o_cnt <= o_cnt + 1'b1;
         end
         if (i_ibus_ack) begin
            fetched <= 1'b1;
            taken_r <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (fetched && i_rf_ready) begin
                  fetched <= 1'b0;
                  state   <= two_stage ? INIT : RUN;
               end
            end
            INIT: begin
               // compare is complete on the last bit of the first pass
               if (o_cnt_done) begin
                  taken_r <= take_branch;
                  state   <= store_op ? WAIT : RUN;
               end
            end
            RUN: begin
               if (o_cnt_done) begin
                  state <= IDLE;
               end
            end
            WAIT: begin
               if (i_dbus_ack) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // counter parks at zero between phases, and only a store ever waits on the data bus
   a_state_legal: assert property (@(posedge clk) disable iff (i_rst)
      !cnt_en |-> (o_cnt == '0) && ((state != WAIT) || store_op));

   // no instruction may land while the store still owns the data bus
   a_dbus_excl: assert property (@(posedge clk) disable iff (i_rst)
      o_dbus_cyc |-> !i_ibus_ack);

endmodule

//--- source/serial_alu.sv
`timescale 1ns/1ps
module serial_alu (
   input  logic    clk,
   alu_ctrl_if.alu ctl,
   input  logic    i_rs1,
   input  logic    i_rs2,
   input  logic    i_imm,
   output logic    o_rd
);
   import serial_pkg::*;

   logic op_b;
   logic b_inv;
   logic c_in;
   logic sum;
   logic c_out;
   logic carry_r;
   logic en_q;
   logic init_q;
   logic start;
   logic first_run;
   logic eq_prev;
   logic lt_prev;
   logic eq_now;
   logic lt_uns_now;
   logic lt_sgn_now;
   logic cmp_now;
   logic eq_r;
   logic lt_r;
   logic cmp_r;
   logic bool_res;

   assign op_b = ctl.op_b_imm ? i_imm : i_rs2;

   // carry restarts on the first bit of a pass, subtract adds the inverted operand plus one
   assign b_inv = op_b ^ ctl.sub;
   assign c_in  = en_q ? carry_r : ctl.sub;
   assign sum   = i_rs1 ^ b_inv ^ c_in;
   assign c_out = (i_rs1 & b_inv) | (c_in & (i_rs1 ^ b_inv));

   assign start     = ctl.init && !init_q;
   assign first_run = ctl.en && !ctl.init && init_q;

   // each bit is treated as if it were the msb, so the last one settles the answer
   assign eq_prev    = start ? 1'b1 : eq_r;
   assign lt_prev    = start ? 1'b0 : lt_r;
   assign eq_now     = eq_prev & (i_rs1 ~^ op_b);
   assign lt_uns_now = (~i_rs1 & op_b) | ((i_rs1 ~^ op_b) & lt_prev);
   assign lt_sgn_now = (i_rs1 & ~op_b) | ((i_rs1 ~^ op_b) & lt_prev);
   assign cmp_now    = ctl.cmp_eq ? eq_now : (ctl.cmp_uns ? lt_uns_now : lt_sgn_now);
   assign ctl.cmp    = cmp_now;

   always_comb begin
      case (ctl.bool_op)
         BOOL_OR:  bool_res = i_rs1 | op_b;
         BOOL_AND: bool_res = i_rs1 & op_b;
         default:  bool_res = i_rs1 ^ op_b;
      endcase
   end

   // slt writes the compare into bit 0 and zeros above it
   always_comb begin
      case (ctl.rd_sel)
         ALU_LT:   o_rd = first_run & cmp_r;
         ALU_BOOL: o_rd = bool_res;
         default:  o_rd = sum;
      endcase
   end

   always_ff @(posedge clk) begin
      en_q   <= ctl.en;
      init_q <= ctl.init;
      if (ctl.en) begin
         carry_r <= c_out;
         eq_r    <= eq_now;
         lt_r    <= lt_uns_now;
         cmp_r   <= cmp_now;
      end
   end

endmodule

//--- source/serial_regfile.sv
`timescale 1ns/1ps
module serial_regfile (
   input  logic                              clk,
   input  logic                              i_rst,
   input  logic                              i_rs_en,
   input  logic                              i_rd_en,
   input  logic [serial_pkg::REG_ADDR_W-1:0] i_rd_addr,
   input  logic [serial_pkg::REG_ADDR_W-1:0] i_rs1_addr,
   input  logic [serial_pkg::REG_ADDR_W-1:0] i_rs2_addr,
   input  logic [serial_pkg::CNT_W-1:0]      i_cnt,
   input  logic                              i_rd,
   output logic                              o_rs1,
   output logic                              o_rs2,
   output logic                              o_ready
);
   import serial_pkg::*;

   localparam int IDX_W = REG_ADDR_W + CNT_W;

   // one bit per entry, index is {register, bit}
   logic mem [0:2**IDX_W-1];
   logic rs_en_q;

   always_ff @(posedge clk) begin
      if (i_rd_en && (i_rd_addr != '0)) begin
         mem[{i_rd_addr, i_cnt}] <= i_rd;
      end
   end

   // x0 is never written, so its reads are forced low here
   assign o_rs1 = i_rs_en && (i_rs1_addr != '0) && mem[{i_rs1_addr, i_cnt}];
   assign o_rs2 = i_rs_en && (i_rs2_addr != '0) && mem[{i_rs2_addr, i_cnt}];

   // ready one cycle after a new read request opens
   always_ff @(posedge clk) begin
      if (i_rst) begin
         rs_en_q <= 1'b0;
         o_ready <= 1'b0;
      end else begin
         rs_en_q <= i_rs_en;
         o_ready <= i_rs_en && !rs_en_q;
      end
   end

   // rd is written LSB first without gaps, so a bit of rs1 == rd is read before it changes
   a_wr_order: assert property (@(posedge clk) disable iff (i_rst)
      i_rd_en && (i_cnt != '0) |-> $past(i_rd_en) && ($past(i_cnt) == i_cnt - 1'b1));

endmodule

//--- source/serial_bufreg.sv
`timescale 1ns/1ps
module serial_bufreg (
   input  logic                         clk,
   input  logic                         i_en,
   input  logic [serial_pkg::CNT_W-1:0] i_cnt,
   input  logic                         i_rs1,
   input  logic                         i_rs2,
   input  logic                         i_imm,
   output serial_pkg::word_t            o_dbus_adr,
   output serial_pkg::word_t            o_dbus_dat
);
   import serial_pkg::*;

   word_t adr_q;
   logic  c_in;
   logic  c_out;
   logic  sum;
   logic  carry_r;

   // rs1 + imm, one bit per cycle
   assign c_in  = (i_cnt != '0) && carry_r;
   assign sum   = i_rs1 ^ i_imm ^ c_in;
   assign c_out = (i_rs1 & i_imm) | (c_in & (i_rs1 ^ i_imm));

   always_ff @(posedge clk) begin
      if (i_en) begin
         carry_r    <= c_out;
         adr_q      <= {sum, adr_q[31:1]};
         o_dbus_dat <= {i_rs2, o_dbus_dat[31:1]};
      end
   end

   // word stores only
   assign o_dbus_adr = {adr_q[31:2], 2'b00};

endmodule

//--- source/serial_ctrl.sv
`timescale 1ns/1ps
module serial_ctrl #(
   parameter serial_pkg::word_t RESET_PC = '0
) (
   input  logic                         clk,
   input  logic                         i_rst,
   input  logic                         i_pc_en,
   input  logic                         i_jump,
   input  logic [serial_pkg::CNT_W-1:0] i_cnt,
   input  logic                         i_imm,
   input  logic                         i_fetch,
   input  logic                         i_ibus_ack,
   output logic                         o_ibus_cyc,
   output serial_pkg::word_t            o_ibus_adr,
   output logic                         o_pc_bit
);

   logic boot;
   logic b4;
   logic c4_in;
   logic c4_out;
   logic c4_q;
   logic sum4;
   logic cimm_in;
   logic cimm_out;
   logic cimm_q;
   logic sumimm;

   // the pc doubles as the fetch address and rotates through bit 0
   assign b4     = (i_cnt == 2);
   assign c4_in  = (i_cnt != '0) && c4_q;
   assign sum4   = o_ibus_adr[0] ^ b4 ^ c4_in;
   assign c4_out = (o_ibus_adr[0] & b4) | (c4_in & (o_ibus_adr[0] ^ b4));

   assign cimm_in  = (i_cnt != '0) && cimm_q;
   assign sumimm   = o_ibus_adr[0] ^ i_imm ^ cimm_in;
   assign cimm_out = (o_ibus_adr[0] & i_imm) | (cimm_in & (o_ibus_adr[0] ^ i_imm));

   // jal links pc+4, auipc writes pc+imm
   assign o_pc_bit = i_jump ? sum4 : sumimm;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_ibus_adr <= RESET_PC;
         o_ibus_cyc <= 1'b0;
         boot       <= 1'b1;
         c4_q       <= 1'b0;
         cimm_q     <= 1'b0;
      end else begin
         boot <= 1'b0;
         if (i_ibus_ack) begin
            o_ibus_cyc <= 1'b0;
         end else if (i_fetch || boot) begin
            o_ibus_cyc <= 1'b1;
         end
         if (i_pc_en) begin
            o_ibus_adr <= {(i_jump ? sumimm : sum4), o_ibus_adr[31:1]};
            c4_q       <= c4_out;
            cimm_q     <= cimm_out;
         end
      end
   end

   // fetch address held steady for the whole bus cycle
   a_ibus_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc && $stable(o_ibus_adr));

endmodule

//--- source/serial_core.sv
`timescale 1ns/1ps
module serial_core #(
   parameter serial_pkg::word_t RESET_PC = '0
) (
   input  logic              clk,
   input  logic              i_rst,
   output logic              o_ibus_cyc,
   output serial_pkg::word_t o_ibus_adr,
   input  logic              i_ibus_ack,
   input  serial_pkg::word_t i_ibus_rdt,
   output logic              o_dbus_cyc,
   output logic              o_dbus_we,
   output serial_pkg::word_t o_dbus_adr,
   output serial_pkg::word_t o_dbus_dat,
   input  logic              i_dbus_ack
);
   import serial_pkg::*;

   logic [CNT_W-1:0]      cnt;
   logic                  cnt_done;
   logic                  rs_en;
   logic                  rd_en;
   logic [REG_ADDR_W-1:0] rd_addr;
   logic [REG_ADDR_W-1:0] rs1_addr;
   logic [REG_ADDR_W-1:0] rs2_addr;
   logic                  rs1;
   logic                  rs2;
   logic                  rf_ready;
   logic                  imm_bit;
   rd_src_t               rd_sel_src;
   logic                  pc_en;
   logic                  jump;
   logic                  bufreg_en;
   logic                  fetch;
   logic                  pc_bit;
   logic                  alu_rd;
   logic                  rd_bit;

   alu_ctrl_if alu_if ();

   // write-back source for rd
   assign rd_bit = (rd_sel_src == RD_IMM) ? imm_bit :
                   (rd_sel_src == RD_PC)  ? pc_bit  : alu_rd;

   // next fetch after the pc pass, except a store which waits for its ack
   assign fetch     = (cnt_done && pc_en && !bufreg_en) || (o_dbus_cyc && i_dbus_ack);
   assign o_dbus_we = o_dbus_cyc;

   serial_decode u_decode (
      .clk (clk), .i_rst (i_rst), .i_ibus_ack (i_ibus_ack), .i_ibus_rdt (i_ibus_rdt),
      .i_rf_ready (rf_ready), .i_dbus_ack (i_dbus_ack), .o_cnt (cnt), .o_cnt_done (cnt_done),
      .o_rf_rs_en (rs_en), .o_rf_rd_en (rd_en), .o_rf_rd_addr (rd_addr),
      .o_rf_rs1_addr (rs1_addr), .o_rf_rs2_addr (rs2_addr), .o_imm (imm_bit),
      .o_rd_sel_src (rd_sel_src), .o_pc_en (pc_en), .o_jump (jump),
      .o_bufreg_en (bufreg_en), .o_dbus_cyc (o_dbus_cyc), .alu (alu_if.decode)
   );

   serial_alu u_alu (
      .clk (clk), .ctl (alu_if.alu), .i_rs1 (rs1), .i_rs2 (rs2), .i_imm (imm_bit),
      .o_rd (alu_rd)
   );

   serial_regfile u_regfile (
      .clk (clk), .i_rst (i_rst), .i_rs_en (rs_en), .i_rd_en (rd_en), .i_rd_addr (rd_addr),
      .i_rs1_addr (rs1_addr), .i_rs2_addr (rs2_addr), .i_cnt (cnt), .i_rd (rd_bit),
      .o_rs1 (rs1), .o_rs2 (rs2), .o_ready (rf_ready)
   );

   serial_bufreg u_bufreg (
      .clk (clk), .i_en (bufreg_en), .i_cnt (cnt), .i_rs1 (rs1), .i_rs2 (rs2),
      .i_imm (imm_bit), .o_dbus_adr (o_dbus_adr), .o_dbus_dat (o_dbus_dat)
   );

   serial_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk (clk), .i_rst (i_rst), .i_pc_en (pc_en), .i_jump (jump), .i_cnt (cnt),
      .i_imm (imm_bit), .i_fetch (fetch), .i_ibus_ack (i_ibus_ack),
      .o_ibus_cyc (o_ibus_cyc), .o_ibus_adr (o_ibus_adr), .o_pc_bit (pc_bit)
   );

endmodule

//--- bench/tb_core.sv
`timescale 1ns/1ps
module tb_core;
   import serial_pkg::*;

   localparam word_t START_PC = 32'h0000_0100;
   localparam int    MAX_DLY  = 3;
   localparam logic [6:0] OP_IMM = 7'b0010011;
   localparam logic [6:0] OP_REG = 7'b0110011;
   localparam logic [6:0] OP_LUI = 7'b0110111;
   localparam logic [6:0] OP_AUI = 7'b0010111;
   localparam logic [6:0] OP_JAL = 7'b1101111;
   localparam logic [6:0] OP_BR  = 7'b1100011;
   localparam logic [6:0] OP_SW  = 7'b0100011;
   // funct3 lists, entry k at bits 3k+2:3k
   localparam logic [20:0] R_F3 = {3'd3, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};
   localparam logic [17:0] I_F3 = {3'd3, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0};
   localparam logic [17:0] B_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

   logic  clk;
   logic  i_rst;
   logic  ibus_cyc;
   word_t ibus_adr;
   logic  ibus_ack;
   word_t ibus_rdt;
   logic  dbus_cyc;
   logic  dbus_we;
   word_t dbus_adr;
   word_t dbus_dat;
   logic  dbus_ack;

   word_t       prog[$];
   word_t       exp_adr_q[$];
   word_t       exp_dat_q[$];
   word_t       mreg [0:31];
   word_t       mpc;
   word_t       end_adr;
   word_t       held_iadr;
   word_t       held_dadr;
   word_t       held_ddat;
   logic        fetch_seen;
   logic        store_seen;
   logic        done;
   logic [31:0] seed;
   logic [11:0] store_off;
   int          errors;
   int          fetches;
   int          stores;
   int          cycles;
   int          limit;
   int          ibus_wait;
   int          dbus_wait;

   serial_core #(
      .RESET_PC (START_PC)
   ) UUT (
      .clk (clk), .i_rst (i_rst), .o_ibus_cyc (ibus_cyc), .o_ibus_adr (ibus_adr),
      .i_ibus_ack (ibus_ack), .i_ibus_rdt (ibus_rdt), .o_dbus_cyc (dbus_cyc),
      .o_dbus_we (dbus_we), .o_dbus_adr (dbus_adr), .o_dbus_dat (dbus_dat),
      .i_dbus_ack (dbus_ack)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] rnd();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                    input logic [2:0] f3, input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, OP_IMM};
   endfunction

   function automatic word_t s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_SW};
   endfunction

   function automatic word_t b_type(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                    input logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
   endfunction

   function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                    input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic word_t j_type(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
   endfunction

   // instruction memory, a jump to self outside the program
   function automatic word_t prog_word(input word_t adr);
      int idx;
      idx = int'((adr - START_PC) >> 2);
      if ((adr >= START_PC) && (idx < prog.size())) begin
         return prog[idx];
      end
      return j_type(21'd0, 5'd0);
   endfunction

   task automatic emit_store(input logic [4:0] rs);
      prog.push_back(s_type(store_off, rs, 5'd0));
      store_off = store_off + 12'd4;
   endtask

   // ISA model: runs one instruction, queues its store, returns the next pc
   function automatic word_t ref_exec(input word_t ins);
      word_t a;
      word_t b;
      word_t res;
      word_t nxt;
      logic  take;
      a    = mreg[ins[19:15]];
      b    = mreg[ins[24:20]];
      nxt  = mpc + 32'd4;
      res  = '0;
      take = 1'b0;
      case (ins[6:0])
         OP_IMM, OP_REG: begin
            if (!ins[5]) begin
               b = {{20{ins[31]}}, ins[31:20]};
            end
            case (ins[14:12])
               3'b000:  res = (ins[5] && ins[30]) ? a - b : a + b;
               3'b010:  res = {31'b0, $signed(a) < $signed(b)};
               3'b011:  res = {31'b0, a < b};
               3'b100:  res = a ^ b;
               3'b110:  res = a | b;
               default: res = a & b;
            endcase
         end
         OP_LUI: res = {ins[31:12], 12'b0};
         OP_AUI: res = mpc + {ins[31:12], 12'b0};
         OP_JAL: begin
            res = mpc + 32'd4;
            nxt = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         OP_BR: begin
            case (ins[14:12])
               3'b000:  take = (a == b);
               3'b001:  take = (a != b);
               3'b100:  take = $signed(a) < $signed(b);
               3'b101:  take = $signed(a) >= $signed(b);
               3'b110:  take = a < b;
               default: take = a >= b;
            endcase
            if (take) begin
               nxt = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         OP_SW: begin
            exp_adr_q.push_back((a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) & ~32'h3);
            exp_dat_q.push_back(b);
         end
         default: ;
      endcase
      if ((ins[6:0] != OP_BR) && (ins[6:0] != OP_SW) && (ins[11:7] != 5'd0)) begin
         mreg[ins[11:7]] = res;
      end
      return nxt;
   endfunction

   task automatic check_fetch(input word_t got, input word_t exp);
      if (got !== exp) begin
         errors++;
         $display("Fail %0t: fetch address %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_store(input word_t adr, input word_t dat,
                              input word_t exp_adr, input word_t exp_dat);
      if ((adr !== exp_adr) || (dat !== exp_dat)) begin
         errors++;
         $display("Fail %0t: store %h to %h, expected %h to %h", $time, dat, adr,
                  exp_dat, exp_adr);
      end
   endtask

   initial begin
      logic [31:0] r;
      clk       = 1'b0;
      i_rst     = 1'b1;
      ibus_ack  = 1'b0;
      ibus_rdt  = '0;
      dbus_ack  = 1'b0;
      seed      = 32'd37428;
      store_off = 12'h200;
      errors    = 0;
      fetches   = 0;
      stores    = 0;
      cycles    = 0;
      ibus_wait = -1;
      dbus_wait = -1;
      fetch_seen = 1'b0;
      store_seen = 1'b0;
      done      = 1'b0;
      // x1 and x2 random, x3 is x1 with its sign bit flipped, x7 counts untaken paths
      for (int k = 1; k <= 2; k++) begin
         r = rnd();
         prog.push_back(u_type(r[31:12], 5'(k), OP_LUI));
         r = rnd();
         prog.push_back(i_type(r[11:0], 5'(k), 3'd0, 5'(k)));
      end
      prog.push_back(u_type(20'h80000, 5'd4, OP_LUI));
      prog.push_back(r_type(7'h00, 5'd4, 5'd1, 3'd4, 5'd3));
      prog.push_back(i_type(12'd0, 5'd0, 3'd0, 5'd7));
      for (int k = 0; k < 7; k++) begin
         prog.push_back(r_type((k == 1) ? 7'h20 : 7'h00, (k > 4) ? 5'd3 : 5'd2, 5'd1,
                               R_F3[3*k +: 3], 5'd5));
         emit_store(5'd5);
      end
      for (int k = 0; k < 6; k++) begin
         r = rnd();
         prog.push_back(i_type(r[11:0], 5'd1, I_F3[3*k +: 3], 5'd5));
         emit_store(5'd5);
      end
      prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
      emit_store(5'd0);
      r = rnd();
      prog.push_back(u_type(r[31:12], 5'd5, OP_LUI));
      emit_store(5'd5);
      r = rnd();
      prog.push_back(u_type(r[31:12], 5'd5, OP_AUI));
      emit_store(5'd5);
      prog.push_back(j_type(21'd8, 5'd5));
      prog.push_back(i_type(12'd1, 5'd7, 3'd0, 5'd7));
      emit_store(5'd5);
      // every branch on equal operands and on operands of opposite sign
      for (int k = 0; k < 6; k++) begin
         for (int p = 0; p < 2; p++) begin
            prog.push_back(b_type(13'd8, (p == 1) ? 5'd3 : 5'd1, 5'd1, B_F3[3*k +: 3]));
            prog.push_back(i_type(12'd1, 5'd7, 3'd0, 5'd7));
         end
      end
      emit_store(5'd7);
      prog.push_back(j_type(21'd0, 5'd0));
      end_adr = START_PC + 32'(4 * (prog.size() - 1));
      for (int k = 0; k < 32; k++) begin
         mreg[k] = '0;
      end
      mpc   = START_PC;
      limit = (prog.size() + 1) * (96 + 2 * MAX_DLY) + 4;
      repeat (4) @(posedge clk);
      #1 i_rst = 1'b0;
      wait (done);
      if (exp_adr_q.size() != 0) begin
         errors++;
         $display("%0d expected stores were never issued", exp_adr_q.size());
      end
      $display("fetches %0d  stores %0d  errors %0d", fetches, stores, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // bus slaves answer each request after a random wait
   always @(posedge clk) begin
      #1;
      if (ibus_ack) begin
         ibus_ack = 1'b0;
      end else if (ibus_cyc) begin
         if (ibus_wait < 0) begin
            ibus_wait = int'((rnd() >> 16) % (MAX_DLY + 1));
         end
         if (ibus_wait == 0) begin
            ibus_ack  = 1'b1;
            ibus_rdt  = prog_word(ibus_adr);
            ibus_wait = -1;
         end else begin
            ibus_wait--;
         end
      end
      if (dbus_ack) begin
         dbus_ack = 1'b0;
      end else if (dbus_cyc) begin
         if (dbus_wait < 0) begin
            dbus_wait = int'((rnd() >> 16) % (MAX_DLY + 1));
         end
         if (dbus_wait == 0) begin
            dbus_ack  = 1'b1;
            dbus_wait = -1;
         end else begin
            dbus_wait--;
         end
      end
   end

   // compare each new request with the model, then watch it stay put until the ack
   always @(posedge clk) begin
      #1;
      cycles++;
      if (ibus_cyc && !fetch_seen) begin
         fetch_seen = 1'b1;
         held_iadr  = ibus_adr;
         fetches++;
         check_fetch(ibus_adr, mpc);
         if (mpc == end_adr) begin
            done = 1'b1;
         end else begin
            mpc = ref_exec(prog_word(mpc));
         end
      end else if (ibus_cyc && (ibus_adr !== held_iadr)) begin
         errors++;
         $display("Fail %0t: fetch address moved from %h to %h", $time, held_iadr, ibus_adr);
      end
      if (!ibus_cyc) begin
         fetch_seen = 1'b0;
      end
      if (dbus_cyc && !store_seen) begin
         store_seen = 1'b1;
         held_dadr  = dbus_adr;
         held_ddat  = dbus_dat;
         stores++;
         if (dbus_we !== 1'b1) begin
            errors++;
            $display("Fail %0t: store request without write enable", $time);
         end
         if (exp_adr_q.size() == 0) begin
            errors++;
            $display("store to %h was issued when none was expected", dbus_adr);
         end else begin
            check_store(dbus_adr, dbus_dat, exp_adr_q.pop_front(), exp_dat_q.pop_front());
         end
      end else if (dbus_cyc && ((dbus_adr !== held_dadr) || (dbus_dat !== held_ddat))) begin
         errors++;
         $display("Fail %0t: store moved to %h at %h while waiting", $time, dbus_dat, dbus_adr);
      end
      if (!dbus_cyc) begin
         store_seen = 1'b0;
      end
      if ((cycles > limit) && !done) begin
         errors++;
         $display("run stopped after %0d cycles before reaching the end of the program",
                  cycles);
         done = 1'b1;
      end
   end

endmodule

//--- tb.f
source/serial_pkg.sv
source/alu_ctrl_if.sv
source/serial_decode.sv
source/serial_alu.sv
source/serial_regfile.sv
source/serial_bufreg.sv
source/serial_ctrl.sv
source/serial_core.sv
bench/tb_core.sv
